// ==== game_link.f ====
src/game_link_pkg.sv
src/baud_tick_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_logic.sv
src/link_fsm.sv
src/game_link_top.sv
tb/game_link_props.sv
tb/game_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the game link testbench with Verilator, run it and check the log

verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module game_link_tb \
    -f game_link.f > build.log 2>&1 || { cat build.log; echo "BUILD ERROR"; exit 1; }

./obj_dir/Vgame_link_tb > sim.log 2>&1
cat sim.log

grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/game_link_tb.sv ====
// game link directed testbench
`timescale 1ns/1ps
`default_nettype none

module game_link_tb;

    localparam int TICK_DIV  = 4;
    localparam int BIT_CYC   = TICK_DIV * game_link_pkg::OVERSAMPLE;
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int QUIET_CYC = FRAME_CYC + 2 * BIT_CYC; // longer than any frame
    localparam int N_TESTS   = 6;

    logic                 clk;
    logic                 rst;
    logic                 rx;
    logic                 multiplayer;
    logic                 start;
    logic                 game_over;
    logic                 player_hit;
    logic                 tx;
    logic                 playing;
    logic                 won;
    logic                 lost;
    logic                 peer_hit;
    game_link_pkg::char_t last_char;
    int                   peer_hits;
    int                   seed;

    game_link_top #(.TICK_DIV(TICK_DIV)) dut (
        .clk(clk), .rst(rst), .rx(rx), .multiplayer(multiplayer), .start(start),
        .game_over(game_over), .player_hit(player_hit), .tx(tx), .playing(playing),
        .won(won), .lost(lost), .peer_hit(peer_hit), .last_char(last_char)
    );

    bind link_fsm game_link_props u_fsm_props (
        .clk(clk), .rst(rst), .multiplayer(multiplayer), .state(state),
        .send_ready(send_ready), .send_lose(send_lose), .send_hit(send_hit),
        .won(won), .lost(lost), .tx(1'b1), .busy(1'b1)
    );

    bind uart_tx game_link_props u_tx_props (
        .clk(clk), .rst(rst), .multiplayer(1'b1), .state(game_link_pkg::IDLE),
        .send_ready(1'b0), .send_lose(1'b0), .send_hit(1'b0),
        .won(1'b0), .lost(1'b0), .tx(tx), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst === 1'b1)
            peer_hits <= 0;
        else if (peer_hit === 1'b1)
            peer_hits <= peer_hits + 1;
    end

    initial begin
        repeat (N_TESTS * 40 * FRAME_CYC) @(posedge clk);
        finish_with_failure("watchdog expired before the tests finished");
    end

    // ****************************************
    // reporting and checks
    // ****************************************

    task automatic finish_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp)
        else finish_with_failure($sformatf("[FAIL] %s: got 0x%02h, expected 0x%02h",
                                           name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp)
        else finish_with_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
                                           name, got, exp));
    endtask

    // ****************************************
    // stimulus and peer model
    // ****************************************

    task automatic pulse_inputs(input logic s, input logic h, input logic g);
        @(posedge clk);
        #1;
        start      = s;
        player_hit = h;
        game_over  = g;
        @(posedge clk);
        #1;
        start      = 1'b0;
        player_hit = 1'b0;
        game_over  = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        #1;
        rx = b;
        repeat (BIT_CYC - 1) @(posedge clk);
    endtask

    task automatic send_char(input game_link_pkg::char_t c, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(c[i]);              // lsb first
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);                  // one idle bit after the frame
    endtask

    task automatic expect_char(input game_link_pkg::char_t exp);
        int                   waited;
        game_link_pkg::char_t got;
        waited = 0;
        while (tx !== 1'b0 && waited < 3 * FRAME_CYC) begin
            @(negedge clk);
            waited++;
        end
        assert (tx === 1'b0)
        else finish_with_failure("no frame started on tx within three frame times");
        repeat (BIT_CYC / 2) @(negedge clk);  // middle of the start bit
        check_flag("tx start bit", tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            got[i] = tx;
        end
        repeat (BIT_CYC) @(negedge clk);
        check_flag("tx stop bit", tx, 1'b1);
        check_value("tx char", got, exp);
    endtask

    task automatic expect_no_frame(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (tx === 1'b1)
            else finish_with_failure("a frame appeared on tx while the link was off");
        end
    endtask

    // wait out a repeated R still on the line
    task automatic wait_tx_quiet();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYC && waited < 3 * FRAME_CYC) begin
            @(negedge clk);
            waited++;
            if (tx === 1'b1) quiet++;
            else quiet = 0;
        end
        assert (quiet >= QUIET_CYC)
        else finish_with_failure("tx line kept sending and never went quiet");
    endtask

    // ****************************************
    // tests
    // ****************************************

    task automatic test_reset_single_mode();
        @(negedge clk);
        check_flag("tx", tx, 1'b1);
        check_flag("playing", playing, 1'b0);
        check_flag("won", won, 1'b0);
        check_flag("lost", lost, 1'b0);
        pulse_inputs(1'b1, 1'b0, 1'b0);
        pulse_inputs(1'b0, 1'b1, 1'b0);
        pulse_inputs(1'b0, 1'b0, 1'b1);
        expect_no_frame(3 * FRAME_CYC);
        check_flag("lost", lost, 1'b0);
    endtask

    task automatic test_ready_exchange();
        @(posedge clk);
        #1;
        multiplayer = 1'b1;
        pulse_inputs(1'b1, 1'b0, 1'b0);
        expect_char(game_link_pkg::CHAR_READY);
        check_flag("playing", playing, 1'b0);
        expect_char(game_link_pkg::CHAR_READY);   // repeated until answered
        send_char(game_link_pkg::CHAR_READY, 1'b1);
        @(negedge clk);
        check_flag("playing", playing, 1'b1);
        check_value("last_char", last_char, game_link_pkg::CHAR_READY);
    endtask

    task automatic test_hits();
        int hits_before;
        wait_tx_quiet();
        pulse_inputs(1'b0, 1'b1, 1'b0);
        expect_char(game_link_pkg::CHAR_HIT);
        hits_before = peer_hits;
        send_char(game_link_pkg::CHAR_HIT, 1'b1);
        @(negedge clk);
        check_value("peer_hit count", 8'(peer_hits - hits_before), 8'd1);
        check_flag("playing", playing, 1'b1);
        check_value("last_char", last_char, game_link_pkg::CHAR_HIT);
    endtask

    task automatic test_losing();
        pulse_inputs(1'b0, 1'b0, 1'b1);
        @(negedge clk);
        check_flag("lost", lost, 1'b1);
        check_flag("playing", playing, 1'b0);
        expect_char(game_link_pkg::CHAR_LOSE);
    endtask

    task automatic test_winning();
        pulse_inputs(1'b1, 1'b0, 1'b0);
        expect_char(game_link_pkg::CHAR_READY);
        send_char(game_link_pkg::CHAR_READY, 1'b1);
        @(negedge clk);
        check_flag("playing", playing, 1'b1);
        send_char(game_link_pkg::CHAR_LOSE, 1'b1);
        @(negedge clk);
        check_flag("won", won, 1'b1);
        check_flag("lost", lost, 1'b0);
        check_flag("playing", playing, 1'b0);
    endtask

    task automatic test_char_coverage();
        int                   rnd;
        game_link_pkg::char_t c;
        game_link_pkg::char_t prev;
        pulse_inputs(1'b1, 1'b0, 1'b0);
        send_char(game_link_pkg::CHAR_READY, 1'b1);
        @(negedge clk);
        check_flag("playing", playing, 1'b1);
        for (int i = 0; i < 8; i++) begin
            do begin
                rnd = $random(seed);
                c   = rnd[7:0];
            end while (c == game_link_pkg::CHAR_READY || c == game_link_pkg::CHAR_LOSE
                       || c == game_link_pkg::CHAR_HIT);
            send_char(c, 1'b1);
            @(negedge clk);
            check_value("last_char", last_char, c);
            check_flag("playing", playing, 1'b1);
        end
        prev = last_char;
        send_char(~prev, 1'b0);           // broken stop bit
        @(negedge clk);
        check_value("last_char", last_char, prev);
        check_flag("playing", playing, 1'b1);
    endtask

    initial begin
        rst         = 1'b1;
        rx          = 1'b1;
        multiplayer = 1'b0;
        start       = 1'b0;
        game_over   = 1'b0;
        player_hit  = 1'b0;
        seed        = 32'hb78c;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_single_mode();
        test_ready_exchange();
        test_hits();
        test_losing();
        test_winning();
        test_char_coverage();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/game_link_props.sv ====
// link and transmitter assertions
`timescale 1ns/1ps
`default_nettype none

module game_link_props (
    input logic                       clk,
    input logic                       rst,
    input logic                       multiplayer,
    input game_link_pkg::link_state_t state,
    input logic                       send_ready,
    input logic                       send_lose,
    input logic                       send_hit,
    input logic                       won,
    input logic                       lost,
    input logic                       tx,
    input logic                       busy
);

    // single mode keeps the link silent
    a_no_req_single: assert property (@(posedge clk) disable iff (rst)
        !(!multiplayer && (state == game_link_pkg::IDLE)
          && (send_ready || send_lose || send_hit)))
        else $error("link request raised in single mode");

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst) busy || tx)
        else $error("tx low while the transmitter is idle");

    a_one_result: assert property (@(posedge clk) disable iff (rst) !(won && lost))
        else $error("won and lost high together");

endmodule

`default_nettype wire

// ==== src/game_link_top.sv ====
// game link top level
`timescale 1ns/1ps
`default_nettype none

module game_link_top #(
    parameter int TICK_DIV = 4  // clocks per oversampling tick
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    input  logic                  multiplayer,
    input  logic                  start,
    input  logic                  game_over,
    input  logic                  player_hit,
    output logic                  tx,
    output logic                  playing,
    output logic                  won,
    output logic                  lost,
    output logic                  peer_hit,
    output game_link_pkg::char_t  last_char
);

    logic                 tick;
    logic                 rx_valid;
    game_link_pkg::char_t rx_data;
    logic                 send_ready;
    logic                 send_lose;
    logic                 send_hit;
    logic                 tx_start;
    game_link_pkg::char_t tx_data;
    logic                 tx_busy;
    logic                 tx_done;

    baud_tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (
        .clk(clk), .rst(rst), .tick(tick)
    );

    uart_tx u_tx (
        .clk(clk), .rst(rst), .tick(tick), .start(tx_start), .data(tx_data),
        .tx(tx), .busy(tx_busy), .done(tx_done)
    );

    uart_rx u_rx (
        .clk(clk), .rst(rst), .tick(tick), .rx(rx), .valid(rx_valid), .data(rx_data)
    );

    uart_logic u_enc (
        .clk(clk), .rst(rst), .send_ready(send_ready), .send_lose(send_lose),
        .send_hit(send_hit), .tx_busy(tx_busy), .tx_done(tx_done),
        .tx_start(tx_start), .tx_data(tx_data)
    );

    link_fsm u_fsm (
        .clk(clk), .rst(rst), .multiplayer(multiplayer), .start(start),
        .game_over(game_over), .player_hit(player_hit), .rx_valid(rx_valid),
        .rx_data(rx_data), .tx_done(tx_done), .send_ready(send_ready),
        .send_lose(send_lose), .send_hit(send_hit), .playing(playing), .won(won),
        .lost(lost), .peer_hit(peer_hit), .last_char(last_char)
    );

endmodule

`default_nettype wire

// ==== src/link_fsm.sv ====
// multiplayer link state machine
`timescale 1ns/1ps
`default_nettype none

module link_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  multiplayer,
    input  logic                  start,
    input  logic                  game_over,
    input  logic                  player_hit,
    input  logic                  rx_valid,
    input  game_link_pkg::char_t  rx_data,
    input  logic                  tx_done,
    output logic                  send_ready,
    output logic                  send_lose,
    output logic                  send_hit,
    output logic                  playing,
    output logic                  won,
    output logic                  lost,
    output logic                  peer_hit,
    output game_link_pkg::char_t  last_char
);

    game_link_pkg::link_state_t state;
    logic                       got_ready;
    logic                       got_lose;
    logic                       got_hit;

    // received character decode
    assign got_ready = rx_valid && (rx_data == game_link_pkg::CHAR_READY);
    assign got_lose  = rx_valid && (rx_data == game_link_pkg::CHAR_LOSE);
    assign got_hit   = rx_valid && (rx_data == game_link_pkg::CHAR_HIT);

    always_ff @(posedge clk) begin
        send_ready <= 1'b0;
        send_lose  <= 1'b0;
        send_hit   <= 1'b0;
        peer_hit   <= 1'b0;
        if (rst) begin
            state <= game_link_pkg::IDLE;
        end else if (!multiplayer) begin
            state <= game_link_pkg::IDLE;   // single mode keeps the link silent
        end else begin
            case (state)
                game_link_pkg::IDLE: begin
                    if (start) begin
                        state      <= game_link_pkg::WAIT_PEER;
                        send_ready <= 1'b1;
                    end
                end
                game_link_pkg::WAIT_PEER: begin
                    if (got_ready)
                        state <= game_link_pkg::PLAYING;
                    else if (tx_done)
                        send_ready <= 1'b1;  // keep repeating R
                end
                game_link_pkg::PLAYING: begin
                    send_hit <= player_hit;
                    peer_hit <= got_hit;
                    if (game_over) begin
                        send_lose <= 1'b1;
                        state     <= game_link_pkg::LOST;
                    end else if (got_lose) begin
                        state <= game_link_pkg::WON;
                    end
                end
                default: begin // WON, LOST
                    if (start) begin
                        state      <= game_link_pkg::WAIT_PEER;
                        send_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    // most recent character of any value
    always_ff @(posedge clk) begin
        if (rst)
            last_char <= '0;
        else if (rx_valid)
            last_char <= rx_data;
    end

    assign playing = (state == game_link_pkg::PLAYING);
    assign won     = (state == game_link_pkg::WON);
    assign lost    = (state == game_link_pkg::LOST);

endmodule

`default_nettype wire

// ==== src/uart_logic.sv ====
// link message encoder
`timescale 1ns/1ps
`default_nettype none

module uart_logic (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  send_ready,
    input  logic                  send_lose,
    input  logic                  send_hit,
    input  logic                  tx_busy,
    input  logic                  tx_done,
    output logic                  tx_start,
    output game_link_pkg::char_t  tx_data
);

    logic                 pend_valid;
    game_link_pkg::char_t pend_char;
    logic                 req;
    game_link_pkg::char_t req_char;

    // ****************************************
    // requests ranked hit then ready then lose
    // ****************************************

    assign req = send_hit | send_ready | send_lose;

    always_comb begin
        if (send_hit)
            req_char = game_link_pkg::CHAR_HIT;
        else if (send_ready)
            req_char = game_link_pkg::CHAR_READY;
        else
            req_char = game_link_pkg::CHAR_LOSE;
    end

    // ****************************************
    // one character holding slot
    // ****************************************

    // line gets one idle cycle after each frame
    assign tx_start = pend_valid && !tx_busy && !tx_done;
    assign tx_data  = pend_char;

    always_ff @(posedge clk) begin
        if (rst)
            pend_valid <= 1'b0;
        else if (req)
            pend_valid <= 1'b1;      // new request overwrites the slot
        else if (tx_start)
            pend_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (req) pend_char <= req_char;
    end

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
// uart 8n1 oversampling receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  rx,
    output logic                  valid,
    output game_link_pkg::char_t  data
);

    localparam int TW = $clog2(game_link_pkg::OVERSAMPLE);
    localparam logic [TW-1:0] LAST_TICK = TW'(game_link_pkg::OVERSAMPLE - 1);
    localparam logic [TW-1:0] MID_TICK  = TW'(game_link_pkg::OVERSAMPLE / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [TW-1:0]        tick_cnt;
    logic [2:0]           bit_cnt;
    game_link_pkg::char_t shreg;

    // two flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        valid <= 1'b0;
        if (rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin // falling start edge
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? RX_IDLE : RX_DATA; // glitch check
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            shreg    <= {rx_sync, shreg[7:1]}; // lsb first
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) state <= RX_STOP;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin // RX_STOP
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            state    <= RX_IDLE;
                            if (rx_sync) begin
                                valid <= 1'b1;
                                data  <= shreg;  // bad stop bit drops the frame
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// uart 8n1 transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  start,
    input  game_link_pkg::char_t  data,
    output logic                  tx,
    output logic                  busy,
    output logic                  done
);

    localparam int TW = $clog2(game_link_pkg::OVERSAMPLE);
    localparam logic [TW-1:0] LAST_TICK = TW'(game_link_pkg::OVERSAMPLE - 1);

    logic [9:0]    frame;    // stop, data lsb first, start
    logic          active;   // line is carrying the frame
    logic [TW-1:0] tick_cnt;
    logic [3:0]    bit_cnt;

    // frame payload loaded on start and shifted out
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            frame <= {1'b1, data, 1'b0};
        end else if (tick && busy && (!active || (tick_cnt == LAST_TICK))) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (rst) begin
            tx       <= 1'b1;           // line idles high
            busy     <= 1'b0;
            active   <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start && !busy) begin
            busy   <= 1'b1;
            active <= 1'b0;             // start edge waits for next tick
        end else if (tick && busy) begin
            if (!active) begin
                active   <= 1'b1;
                tx       <= frame[0];   // start bit
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end else if (tick_cnt == LAST_TICK) begin
                tick_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // end of stop bit
                    tx     <= 1'b1;
                    busy   <= 1'b0;
                    active <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    tx      <= frame[0];
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/baud_tick_gen.sv ====
// oversampling tick timer
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int TICK_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= CNT_W'(TICK_DIV - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CNT_W'(TICK_DIV - 1); // wrap and pulse
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/game_link_pkg.sv ====
// game link shared definitions
`default_nettype none

package game_link_pkg;

    // ****************************************
    // characters on the serial line
    // ****************************************

    typedef logic [7:0] char_t;           // one uart character

    localparam char_t CHAR_READY = 8'h52; // R means waiting for a game
    localparam char_t CHAR_LOSE  = 8'h4C; // L means sender has lost
    localparam char_t CHAR_HIT   = 8'h44; // D means sender scored a hit

    // ticks per serial bit
    localparam int OVERSAMPLE = 16;

    // ****************************************
    // link state machine
    // ****************************************

    typedef enum logic [2:0] {
        IDLE,       // single mode or not started
        WAIT_PEER,  // repeating R until the peer answers
        PLAYING,
        WON,
        LOST
    } link_state_t;

endpackage

`default_nettype wire
